// File: Makefile
# Verilator build and run of the fetch stage testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module if_stage_tb -f if_stage.f -o if_stage_sim
	out="$$(./obj_dir/if_stage_sim)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: bench/if_stage_tb.sv
// testbench for the fetch stage: a table of stimulus and expected values
// is applied one row per clock; combinational outputs are checked in the
// same row, the IF-ID register one row later

`timescale 1ns/1ps
`default_nettype none

`include "if_cfg.svh"

module if_stage_tb import if_addr_pkg::*, if_instr_pkg::*; ();

  localparam int ROW_MAX       = 48;
  localparam int RESET_TIMEOUT = 40;
  localparam int WATCHDOG_NS   = 20000;

  // one table row
  typedef struct {
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_mux;
    irq_vec_t    irq_vec;
    logic [1:0]  irq_bits;   // irq_int, irq_shv
    logic [3:0]  ctl;        // pc_set, fetch_valid, id_in_ready, instr_valid_clear
    logic [1:0]  word_lo;    // forced low bits of the random word
    addr_t       fetch_addr;
    logic [3:0]  errs;       // fetch_err, fetch_err_plus2, pmp_err_if, pmp_err_if_plus2
    addr_t       exp_addr;
    logic [1:0]  exp_sel;    // csr_mtvec_init, minhv
    logic [4:0]  exp_id;     // err, err_plus2 of the word taken, then valid, new, alert
  } row_t;

  logic        clk;
  logic        rst_n;
  addr_t       boot_addr;
  logic        pc_set;
  pc_sel_e     pc_mux;
  exc_pc_sel_e exc_pc_mux;
  irq_vec_t    irq_vec;
  logic        irq_int;
  logic        irq_shv;
  addr_t       csr_mtvec;
  addr_t       csr_mepc;
  addr_t       csr_depc;
  addr_t       branch_target_ex;
  logic        fetch_branch;
  addr_t       fetch_branch_addr;
  logic        csr_mtvec_init;
  logic        minhv;
  logic        fetch_valid;
  instr_t      fetch_rdata;
  addr_t       fetch_addr;
  logic        fetch_err;
  logic        fetch_err_plus2;
  logic        pmp_err_if;
  logic        pmp_err_if_plus2;
  logic        fetch_ready;
  logic        id_in_ready;
  logic        instr_valid_clear;
  logic        instr_valid_id;
  logic        instr_new_id;
  instr_t      instr_rdata_id;
  instr_c_t    instr_rdata_c_id;
  logic        instr_is_compressed_id;
  logic        instr_fetch_err;
  logic        instr_fetch_err_plus2;
  addr_t       pc_id;
  logic        pc_mismatch_alert;

  row_t   rows [ROW_MAX];
  int     n_rows;
  int     cur_row;
  int     errors;
  integer seed;
  instr_t drive_word;

  // model of the IF-ID register, loaded on every accept
  instr_t exp_word;
  addr_t  exp_pc;
  logic   exp_comp;
  logic   exp_err;
  logic   exp_err_plus2;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  if_stage uut (
    .clk_i                    (clk),
    .rst_ni                   (rst_n),
    .boot_addr_i              (boot_addr),
    .pc_set_i                 (pc_set),
    .pc_mux_i                 (pc_mux),
    .exc_pc_mux_i             (exc_pc_mux),
    .irq_vec_i                (irq_vec),
    .irq_int_i                (irq_int),
    .irq_shv_i                (irq_shv),
    .csr_mtvec_i              (csr_mtvec),
    .csr_mepc_i               (csr_mepc),
    .csr_depc_i               (csr_depc),
    .branch_target_ex_i       (branch_target_ex),
    .fetch_branch_o           (fetch_branch),
    .fetch_branch_addr_o      (fetch_branch_addr),
    .csr_mtvec_init_o         (csr_mtvec_init),
    .minhv_o                  (minhv),
    .fetch_valid_i            (fetch_valid),
    .fetch_rdata_i            (fetch_rdata),
    .fetch_addr_i             (fetch_addr),
    .fetch_err_i              (fetch_err),
    .fetch_err_plus2_i        (fetch_err_plus2),
    .pmp_err_if_i             (pmp_err_if),
    .pmp_err_if_plus2_i       (pmp_err_if_plus2),
    .fetch_ready_o            (fetch_ready),
    .id_in_ready_i            (id_in_ready),
    .instr_valid_clear_i      (instr_valid_clear),
    .instr_valid_id_o         (instr_valid_id),
    .instr_new_id_o           (instr_new_id),
    .instr_rdata_id_o         (instr_rdata_id),
    .instr_rdata_c_id_o       (instr_rdata_c_id),
    .instr_is_compressed_id_o (instr_is_compressed_id),
    .instr_fetch_err_o        (instr_fetch_err),
    .instr_fetch_err_plus2_o  (instr_fetch_err_plus2),
    .pc_id_o                  (pc_id),
    .pc_mismatch_alert_o      (pc_mismatch_alert)
  );

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("FAIL row %0d %s: got 0x%h, expected 0x%h", cur_row, name, got, want);
      errors++;
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t want);
    if (got !== want) begin
      $display("FAIL row %0d %s: got 0x%h, expected 0x%h", cur_row, name, got, want);
      errors++;
      abort_run();
    end
  endtask

  task automatic check_instr(input string name, input instr_t got, input instr_t want);
    if (got !== want) begin
      $display("FAIL row %0d %s: got 0x%h, expected 0x%h", cur_row, name, got, want);
      errors++;
      abort_run();
    end
  endtask

  task automatic check_half(input string name, input instr_c_t got, input instr_c_t want);
    if (got !== want) begin
      $display("FAIL row %0d %s: got 0x%h, expected 0x%h", cur_row, name, got, want);
      errors++;
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // table
  ////////////////////////////////////////////////////////////

  // address selection only, no fetch in flight
  task automatic add_sel_row(input logic set, input pc_sel_e sel, input exc_pc_sel_e exc,
                             input irq_vec_t vec, input logic [1:0] irq,
                             input addr_t want_addr, input logic [1:0] want_sel);
    row_t r;
    r.pc_mux     = sel;
    r.exc_mux    = exc;
    r.irq_vec    = vec;
    r.irq_bits   = irq;
    r.ctl        = {set, 1'b0, 1'b1, 1'b0};
    r.word_lo    = 2'b11;
    r.fetch_addr = '0;
    r.errs       = 4'b0000;
    r.exp_addr   = want_addr;
    r.exp_sel    = want_sel;
    r.exp_id     = 5'b00000;
    rows[n_rows] = r;
    n_rows++;
  endtask

  // fetch stream rows, the mux sits on JUMP with bit 0 of the target cleared
  task automatic add_fetch_row(input logic [3:0] ctl, input logic [1:0] lo, input addr_t addr,
                               input logic [3:0] errs, input logic [4:0] want_id);
    row_t r;
    r.pc_mux     = PC_JUMP;
    r.exc_mux    = EXC_PC_EXC;
    r.irq_vec    = '0;
    r.irq_bits   = 2'b00;
    r.ctl        = ctl;
    r.word_lo    = lo;
    r.fetch_addr = addr;
    r.errs       = errs;
    r.exp_addr   = 32'h0000_5122;
    r.exp_sel    = 2'b00;
    r.exp_id     = want_id;
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic build_table();
    // boot base 0x1000 plus offset, init only on pc_set
    add_sel_row(1'b1, PC_BOOT, EXC_PC_EXC, 5'd0, 2'b00, 32'h0000_1080, 2'b10);
    add_sel_row(1'b0, PC_BOOT, EXC_PC_EXC, 5'd0, 2'b00, 32'h0000_1080, 2'b00);
    // shv outside EXC gives no minhv
    add_sel_row(1'b1, PC_JUMP, EXC_PC_EXC, 5'd0, 2'b01, 32'h0000_5122, 2'b00);
    add_sel_row(1'b1, PC_ERET, EXC_PC_EXC, 5'd0, 2'b00, 32'h0000_3456, 2'b00);
    add_sel_row(1'b1, PC_DRET, EXC_PC_EXC, 5'd0, 2'b00, 32'h0000_4a3c, 2'b00);
    // trap vectors off mtvec 0x2003
    add_sel_row(1'b1, PC_EXC, EXC_PC_EXC, 5'd0, 2'b00, 32'h0000_2000, 2'b00);
    add_sel_row(1'b1, PC_EXC, EXC_PC_EXC, 5'd0, 2'b01, 32'h0000_2000, 2'b01);
    add_sel_row(1'b1, PC_EXC, EXC_PC_IRQ, 5'd5, 2'b01, 32'h0000_2000 + 32'd5 * 32'd4, 2'b01);
    // internal interrupt overrides the vector number
    add_sel_row(1'b1, PC_EXC, EXC_PC_IRQ, 5'd5, 2'b10, 32'h0000_2000 + 32'd31 * 32'd4, 2'b00);
    add_sel_row(1'b1, PC_EXC, EXC_PC_DBD, 5'd0, 2'b00, `IF_DM_HALT_ADDR, 2'b00);
    add_sel_row(1'b1, PC_EXC, EXC_PC_DBG_EXC, 5'd0, 2'b00, `IF_DM_EXC_ADDR, 2'b00);

    // sequential stream, steps of 4 and 2
    add_fetch_row(4'b0110, 2'b11, 32'h0000_0100, 4'b0000, 5'b00000);
    add_fetch_row(4'b0110, 2'b01, 32'h0000_0104, 4'b0000, 5'b00110);
    add_fetch_row(4'b0110, 2'b11, 32'h0000_0106, 4'b0000, 5'b00110);
    add_fetch_row(4'b0010, 2'b11, 32'h0000_010A, 4'b0000, 5'b00110);
    // valid holds until cleared
    add_fetch_row(4'b0011, 2'b11, 32'h0000_010A, 4'b0000, 5'b00100);
    add_fetch_row(4'b0010, 2'b11, 32'h0000_010A, 4'b0000, 5'b00000);
    // ID stalled, register holds
    add_fetch_row(4'b0100, 2'b11, 32'h0000_010A, 4'b0000, 5'b00000);
    add_fetch_row(4'b0100, 2'b11, 32'h0000_010A, 4'b0000, 5'b00000);
    add_fetch_row(4'b0110, 2'b11, 32'h0000_010A, 4'b0000, 5'b00000);
    add_fetch_row(4'b0010, 2'b11, 32'h0000_010E, 4'b0000, 5'b00110);
    // wrong next address raises the alert
    add_fetch_row(4'b0011, 2'b11, 32'h0000_0120, 4'b0000, 5'b00101);
    // squashed accept, new pulses but valid stays low
    add_fetch_row(4'b1110, 2'b11, 32'h0000_0120, 4'b0000, 5'b00001);
    add_fetch_row(4'b0010, 2'b11, 32'h0000_0300, 4'b0000, 5'b00010);
    // pc_set between two fetches hides the jump
    add_fetch_row(4'b0110, 2'b11, 32'h0000_0300, 4'b0000, 5'b00000);
    add_fetch_row(4'b1010, 2'b11, 32'h0000_0304, 4'b0000, 5'b00110);
    add_fetch_row(4'b0110, 2'b01, 32'h0000_0400, 4'b0000, 5'b00100);
    // error merging
    add_fetch_row(4'b0110, 2'b11, 32'h0000_0402, 4'b1000, 5'b10110);
    add_fetch_row(4'b0110, 2'b11, 32'h0000_0406, 4'b0110, 5'b10110);
    add_fetch_row(4'b0110, 2'b11, 32'h0000_040A, 4'b0001, 5'b11110);
    add_fetch_row(4'b0110, 2'b01, 32'h0000_040E, 4'b0001, 5'b00110);
    add_fetch_row(4'b0110, 2'b11, 32'h0000_0410, 4'b0001, 5'b00110);
    add_fetch_row(4'b0110, 2'b11, 32'h0000_0414, 4'b0100, 5'b01110);
    add_fetch_row(4'b0011, 2'b11, 32'h0000_0418, 4'b0000, 5'b00110);
    add_fetch_row(4'b0010, 2'b11, 32'h0000_0418, 4'b0000, 5'b00000);
  endtask

  ////////////////////////////////////////////////////////////
  // drive and check
  ////////////////////////////////////////////////////////////

  task automatic apply_row(input row_t r);
    drive_word      = $random(seed);
    drive_word[1:0] = r.word_lo;
    pc_mux          = r.pc_mux;
    exc_pc_mux      = r.exc_mux;
    irq_vec         = r.irq_vec;
    {irq_int, irq_shv} = r.irq_bits;
    {pc_set, fetch_valid, id_in_ready, instr_valid_clear} = r.ctl;
    {fetch_err, fetch_err_plus2, pmp_err_if, pmp_err_if_plus2} = r.errs;
    fetch_rdata     = drive_word;
    fetch_addr      = r.fetch_addr;
  endtask

  task automatic check_row(input row_t r);
    // same cycle
    check_bit("fetch_branch_o", fetch_branch, r.ctl[3]);
    check_addr("fetch_branch_addr_o", fetch_branch_addr, r.exp_addr);
    check_bit("csr_mtvec_init_o", csr_mtvec_init, r.exp_sel[1]);
    check_bit("minhv_o", minhv, r.exp_sel[0]);
    check_bit("fetch_ready_o", fetch_ready, r.ctl[1]);
    check_bit("pc_mismatch_alert_o", pc_mismatch_alert, r.exp_id[0]);
    // IF-ID register, loaded at the start of this row
    check_bit("instr_valid_id_o", instr_valid_id, r.exp_id[2]);
    check_bit("instr_new_id_o", instr_new_id, r.exp_id[1]);
    check_instr("instr_rdata_id_o", instr_rdata_id, exp_word);
    check_half("instr_rdata_c_id_o", instr_rdata_c_id, exp_word[15:0]);
    check_addr("pc_id_o", pc_id, exp_pc);
    check_bit("instr_is_compressed_id_o", instr_is_compressed_id, exp_comp);
    check_bit("instr_fetch_err_o", instr_fetch_err, exp_err);
    check_bit("instr_fetch_err_plus2_o", instr_fetch_err_plus2, exp_err_plus2);
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: test did not finish within %0d ns", WATCHDOG_NS);
    abort_run();
  end

  initial begin : main
    row_t r;
    int   waited;
    seed              = 32'h55fc;
    errors            = 0;
    n_rows            = 0;
    cur_row           = 0;
    drive_word        = '0;
    boot_addr         = 32'h0000_1000;
    csr_mtvec         = 32'h0000_2003;
    csr_mepc          = 32'h0000_3457;
    csr_depc          = 32'h0000_4a3d;
    branch_target_ex  = 32'h0000_5123;
    pc_set            = 1'b0;
    pc_mux            = PC_BOOT;
    exc_pc_mux        = EXC_PC_EXC;
    irq_vec           = '0;
    irq_int           = 1'b0;
    irq_shv           = 1'b0;
    fetch_valid       = 1'b0;
    fetch_rdata       = '0;
    fetch_addr        = '0;
    fetch_err         = 1'b0;
    fetch_err_plus2   = 1'b0;
    pmp_err_if        = 1'b0;
    pmp_err_if_plus2  = 1'b0;
    id_in_ready       = 1'b1;
    instr_valid_clear = 1'b0;
    // register is all zero out of reset
    exp_word          = '0;
    exp_pc            = '0;
    exp_comp          = 1'b0;
    exp_err           = 1'b0;
    exp_err_plus2     = 1'b0;
    build_table();

    waited = 0;
    while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was never released");
      abort_run();
    end

    for (int i = 0; i < n_rows; i++) begin
      r       = rows[i];
      cur_row = i;
      @(posedge clk);
      #10;
      apply_row(r);
      // settled well before the next edge
      #70;
      check_row(r);
      // accept: valid and ready in the same cycle
      if (r.ctl[2] && r.ctl[1]) begin
        exp_word      = drive_word;
        exp_pc        = r.fetch_addr;
        exp_comp      = (r.word_lo != 2'b11);
        exp_err       = r.exp_id[4];
        exp_err_plus2 = r.exp_id[3];
      end
    end

    if (errors == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
// clock and power-on reset for the fetch stage testbench
// 100 ns period, reset held low for the first 16 rising edges

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // free running, 50 ns per half period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // low for 16 rising edges, released 10 ns after the last one
  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    #10;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: common/if_addr_pkg.sv
// address-side types of the fetch stage: PCs and the selectors
// that pick the next fetch address and the trap vector

`default_nettype none

package if_addr_pkg;

  // byte address, also used for every PC
  typedef logic [31:0] addr_t;

  // interrupt vector number, lands at mtvec bits 6..2
  typedef logic [4:0] irq_vec_t;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // target of a trap
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

endpackage

`default_nettype wire

// File: common/if_cfg.svh
// fixed addresses and field positions of the fetch stage
// include wherever the vector or boot addresses are built

`ifndef IF_CFG_SVH
`define IF_CFG_SVH

////////////////////////////////////////////////////////////
// debug entry points
////////////////////////////////////////////////////////////

// halt request entry of the debug module
`define IF_DM_HALT_ADDR 32'h1A110800
// exception taken while already in debug mode
`define IF_DM_EXC_ADDR 32'h1A110808

////////////////////////////////////////////////////////////
// boot and vector layout
////////////////////////////////////////////////////////////

// low byte of the first fetch address after boot
`define IF_BOOT_OFFSET 8'h80
// lowest mtvec bit kept in a vector, bits below come from the cause
`define IF_VEC_BASE_LSB 8
// every internal interrupt shares the NMI slot
`define IF_NMI_VEC 5'd31

`endif

// File: common/if_instr_pkg.sv
// instruction-side types of the fetch stage

`default_nettype none

package if_instr_pkg;

  // full fetched word, compressed or not
  typedef logic [31:0] instr_t;

  // low half word, kept for mtval on compressed instructions
  typedef logic [15:0] instr_c_t;

endpackage

`default_nettype wire

// File: hw/if_id_pipe/if_id_pipe.sv
// instruction side of the fetch stage: takes the prefetch stream,
// flags compressed words, merges bus and PMP errors and fills the IF-ID register

`timescale 1ns/1ps
`default_nettype none

module if_id_pipe import if_addr_pkg::*, if_instr_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // prefetch stream
  input  logic     fetch_valid_i,
  input  instr_t   fetch_rdata_i,
  input  addr_t    fetch_addr_i,
  input  logic     fetch_err_i,
  input  logic     fetch_err_plus2_i,
  input  logic     pmp_err_if_i,
  input  logic     pmp_err_if_plus2_i,

  // pipeline control
  input  logic     id_in_ready_i,
  input  logic     instr_valid_clear_i,
  input  logic     branch_req_i,

  output logic     fetch_ready_o,
  output logic     accept_o,
  output addr_t    fetch_pc_o,
  output logic     if_err_o,

  // IF-ID register
  output logic     instr_valid_id_o,
  output logic     instr_new_id_o,
  output instr_t   instr_rdata_id_o,
  output instr_c_t instr_rdata_c_id_o,
  output logic     instr_is_compressed_id_o,
  output logic     instr_fetch_err_o,
  output logic     instr_fetch_err_plus2_o,
  output addr_t    pc_id_o
);

  logic accept;
  logic instr_is_compressed;
  logic pmp_err_plus2;
  logic instr_err;
  logic instr_err_plus2;
  logic instr_valid_id_d;
  logic instr_valid_id_q;
  logic instr_new_id_q;

  ////////////////////////////////////////////////////////////
  // fetch side
  ////////////////////////////////////////////////////////////

  // ID ready is the only stall source here
  assign fetch_ready_o = id_in_ready_i;
  assign accept        = fetch_valid_i & id_in_ready_i;

  // RVC words never have both low bits set
  assign instr_is_compressed = (fetch_rdata_i[1:0] != 2'b11);

  // a 32-bit word at a halfword offset spills into the next word,
  // whose PMP result comes on the plus2 line
  assign pmp_err_plus2 = fetch_addr_i[1] & ~instr_is_compressed & pmp_err_if_plus2_i;

  // bus error and both PMP checks give one fetch error
  assign instr_err = fetch_err_i | pmp_err_if_i | pmp_err_plus2;

  // mtval needs +2 only when the lower half itself was fine
  assign instr_err_plus2 = (pmp_err_plus2 | fetch_err_plus2_i) & ~pmp_err_if_i;

  assign accept_o   = accept;
  assign fetch_pc_o = fetch_addr_i;
  assign if_err_o   = instr_err;

  ////////////////////////////////////////////////////////////
  // valid and new flags
  ////////////////////////////////////////////////////////////

  // a word taken together with pc_set is squashed, valid then holds
  // until the controller clears it
  assign instr_valid_id_d = (accept & ~branch_req_i) |
                            (instr_valid_id_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_q <= 1'b0;
      instr_new_id_q   <= 1'b0;
    end else begin
      instr_valid_id_q <= instr_valid_id_d;
      // pulses for squashed words too, tracing relies on it
      instr_new_id_q   <= accept;
    end
  end

  assign instr_valid_id_o = instr_valid_id_q;
  assign instr_new_id_o   = instr_new_id_q;

  ////////////////////////////////////////////////////////////
  // IF-ID payload
  ////////////////////////////////////////////////////////////

  // frozen while ID stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o         <= '0;
      instr_rdata_c_id_o       <= '0;
      instr_is_compressed_id_o <= 1'b0;
      instr_fetch_err_o        <= 1'b0;
      instr_fetch_err_plus2_o  <= 1'b0;
      pc_id_o                  <= '0;
    end else if (accept) begin
      // word goes through unexpanded
      instr_rdata_id_o         <= fetch_rdata_i;
      instr_rdata_c_id_o       <= fetch_rdata_i[15:0];
      instr_is_compressed_id_o <= instr_is_compressed;
      instr_fetch_err_o        <= instr_err;
      instr_fetch_err_plus2_o  <= instr_err_plus2;
      pc_id_o                  <= fetch_addr_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // valid may only rise after a handshake on the fetch stream
  // in a cycle without a redirect
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(instr_valid_id_o) |-> $past(fetch_valid_i && id_in_ready_i && !branch_req_i))
    else $error("instr_valid_id_o rose without an accepted fetch");

endmodule

`default_nettype wire

// File: hw/if_stage.sv
// fetch stage top: address selection, IF-ID register and PC check
// side by side, fed by an external prefetch buffer

`timescale 1ns/1ps
`default_nettype none

module if_stage import if_addr_pkg::*, if_instr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  // address selection
  input  addr_t       boot_addr_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_vec_t    irq_vec_i,
  input  logic        irq_int_i,
  input  logic        irq_shv_i,
  input  addr_t       csr_mtvec_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       branch_target_ex_i,
  output logic        fetch_branch_o,
  output addr_t       fetch_branch_addr_o,
  output logic        csr_mtvec_init_o,
  output logic        minhv_o,

  // prefetch stream
  input  logic        fetch_valid_i,
  input  instr_t      fetch_rdata_i,
  input  addr_t       fetch_addr_i,
  input  logic        fetch_err_i,
  input  logic        fetch_err_plus2_i,
  input  logic        pmp_err_if_i,
  input  logic        pmp_err_if_plus2_i,
  output logic        fetch_ready_o,

  // ID stage
  input  logic        id_in_ready_i,
  input  logic        instr_valid_clear_i,
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output instr_t      instr_rdata_id_o,
  output instr_c_t    instr_rdata_c_id_o,
  output logic        instr_is_compressed_id_o,
  output logic        instr_fetch_err_o,
  output logic        instr_fetch_err_plus2_o,
  output addr_t       pc_id_o,

  output logic        pc_mismatch_alert_o
);

  logic  branch_req;
  logic  accept;
  addr_t fetch_pc;
  logic  if_err;

  assign fetch_branch_o = branch_req;

  next_pc_mux u_next_pc_mux (
    .boot_addr_i         (boot_addr_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_vec_i           (irq_vec_i),
    .irq_int_i           (irq_int_i),
    .irq_shv_i           (irq_shv_i),
    .csr_mtvec_i         (csr_mtvec_i),
    .csr_mepc_i          (csr_mepc_i),
    .csr_depc_i          (csr_depc_i),
    .branch_target_ex_i  (branch_target_ex_i),
    .fetch_branch_o      (branch_req),
    .fetch_branch_addr_o (fetch_branch_addr_o),
    .csr_mtvec_init_o    (csr_mtvec_init_o),
    .minhv_o             (minhv_o)
  );

  if_id_pipe u_if_id_pipe (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .fetch_valid_i            (fetch_valid_i),
    .fetch_rdata_i            (fetch_rdata_i),
    .fetch_addr_i             (fetch_addr_i),
    .fetch_err_i              (fetch_err_i),
    .fetch_err_plus2_i        (fetch_err_plus2_i),
    .pmp_err_if_i             (pmp_err_if_i),
    .pmp_err_if_plus2_i       (pmp_err_if_plus2_i),
    .id_in_ready_i            (id_in_ready_i),
    .instr_valid_clear_i      (instr_valid_clear_i),
    .branch_req_i             (branch_req),
    .fetch_ready_o            (fetch_ready_o),
    .accept_o                 (accept),
    .fetch_pc_o               (fetch_pc),
    .if_err_o                 (if_err),
    .instr_valid_id_o         (instr_valid_id_o),
    .instr_new_id_o           (instr_new_id_o),
    .instr_rdata_id_o         (instr_rdata_id_o),
    .instr_rdata_c_id_o       (instr_rdata_c_id_o),
    .instr_is_compressed_id_o (instr_is_compressed_id_o),
    .instr_fetch_err_o        (instr_fetch_err_o),
    .instr_fetch_err_plus2_o  (instr_fetch_err_plus2_o),
    .pc_id_o                  (pc_id_o)
  );

  // compares the live fetch address against the registered PC
  pc_integrity_check u_pc_integrity_check (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .accept_i                 (accept),
    .branch_req_i             (branch_req),
    .if_err_i                 (if_err),
    .fetch_pc_i               (fetch_pc),
    .pc_id_i                  (pc_id_o),
    .instr_is_compressed_id_i (instr_is_compressed_id_o),
    .pc_mismatch_alert_o      (pc_mismatch_alert_o)
  );

endmodule

`default_nettype wire

// File: hw/pc_integrity_check.sv
// flags a fetch address that does not follow the instruction in ID
// by 2 or 4 bytes when no branch came in between

`timescale 1ns/1ps
`default_nettype none

module pc_integrity_check import if_addr_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  accept_i,
  input  logic  branch_req_i,
  input  logic  if_err_i,
  input  addr_t fetch_pc_i,
  input  addr_t pc_id_i,
  input  logic  instr_is_compressed_id_i,
  output logic  pc_mismatch_alert_o
);

  logic  prev_instr_seq_d;
  logic  prev_instr_seq_q;
  addr_t prev_instr_addr_incr;

  // set once a word reaches ID, dropped on any redirect or fetch error
  // since the next address is then not sequential
  assign prev_instr_seq_d = (prev_instr_seq_q | accept_i) & ~branch_req_i & ~if_err_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_instr_seq_q <= 1'b0;
    end else begin
      prev_instr_seq_q <= prev_instr_seq_d;
    end
  end

  // expected PC of the word after the one in ID
  assign prev_instr_addr_incr = pc_id_i + (instr_is_compressed_id_i ? 32'd2 : 32'd4);

  assign pc_mismatch_alert_o = prev_instr_seq_q & (fetch_pc_i != prev_instr_addr_incr);

  // first cycle out of reset has nothing in ID to compare against
  assert property (@(posedge clk_i) $rose(rst_ni) |-> !pc_mismatch_alert_o)
    else $error("pc_mismatch_alert_o high right after reset");

endmodule

`default_nettype wire

// File: hw/pc_select/next_pc_mux.sv
// next fetch address selection and trap vector generation
// purely combinational, drives the branch request to the prefetch buffer

`timescale 1ns/1ps
`default_nettype none

`include "if_cfg.svh"

module next_pc_mux import if_addr_pkg::*; (
  input  addr_t       boot_addr_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_vec_t    irq_vec_i,
  input  logic        irq_int_i,
  input  logic        irq_shv_i,
  input  addr_t       csr_mtvec_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       branch_target_ex_i,
  output logic        fetch_branch_o,
  output addr_t       fetch_branch_addr_o,
  output logic        csr_mtvec_init_o,
  output logic        minhv_o
);

  irq_vec_t irq_vec;
  addr_t    exc_pc;
  addr_t    fetch_addr_n;

  ////////////////////////////////////////////////////////////
  // trap vector
  ////////////////////////////////////////////////////////////

  always_comb begin : exc_pc_mux
    // internal interrupts all share the NMI slot
    irq_vec = irq_int_i ? `IF_NMI_VEC : irq_vec_i;

    unique case (exc_pc_mux_i)
      // exceptions go to the mtvec base
      EXC_PC_EXC:     exc_pc = {csr_mtvec_i[31:`IF_VEC_BASE_LSB], 8'h00};
      // vectored mode, one word per cause
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:`IF_VEC_BASE_LSB], 1'b0, irq_vec, 2'b00};
      EXC_PC_DBD:     exc_pc = `IF_DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `IF_DM_EXC_ADDR;
      default:        exc_pc = {csr_mtvec_i[31:`IF_VEC_BASE_LSB], 8'h00};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // fetch address
  ////////////////////////////////////////////////////////////

  always_comb begin : fetch_addr_mux
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n = {boot_addr_i[31:`IF_VEC_BASE_LSB], `IF_BOOT_OFFSET};
      PC_JUMP: fetch_addr_n = branch_target_ex_i;
      PC_EXC:  fetch_addr_n = exc_pc;
      // return from trap
      PC_ERET: fetch_addr_n = csr_mepc_i;
      // return from debug mode
      PC_DRET: fetch_addr_n = csr_depc_i;
      default: fetch_addr_n = {boot_addr_i[31:`IF_VEC_BASE_LSB], `IF_BOOT_OFFSET};
    endcase
  end

  // every pc_set becomes a branch in the same cycle
  assign fetch_branch_o      = pc_set_i;
  // fetch is halfword aligned, drop bit 0
  assign fetch_branch_addr_o = {fetch_addr_n[31:1], 1'b0};

  // hardware vectoring flag for the CLIC, reported on the trap path
  assign minhv_o = (pc_mux_i == PC_EXC) & irq_shv_i;

  // the CSR file loads mtvec from the boot address on the first jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // selectors and boot address must be sane whenever pc_set is up
  always_comb begin : sel_checks
    if (pc_set_i) begin
      // the controller only ever sends one of the five sources
      assert (!$isunknown(pc_mux_i) && (pc_mux_i inside {PC_BOOT, PC_JUMP, PC_EXC,
                                                         PC_ERET, PC_DRET}))
        else $error("pc_mux_i unknown or out of range on pc_set_i");
      assert (!$isunknown(exc_pc_mux_i))
        else $error("exc_pc_mux_i unknown on pc_set_i");
      // boot offset overwrites the low byte, so the SoC must align it
      assert (boot_addr_i[7:0] == 8'h00)
        else $error("boot_addr_i not 256-byte aligned");
    end
  end

endmodule

`default_nettype wire

// File: if_stage.f
+incdir+common
common/if_addr_pkg.sv
common/if_instr_pkg.sv
hw/pc_select/next_pc_mux.sv
hw/if_id_pipe/if_id_pipe.sv
hw/pc_integrity_check.sv
hw/if_stage.sv
bench/tb_clk_gen.sv
bench/if_stage_tb.sv
